// ==== design/idx_consts.svh ====
// Width, opcode and function-code macros for the decode-execute slice
// Multiplier iteration count for the shift-add unit
`ifndef IDX_CONSTS_SVH
`define IDX_CONSTS_SVH

// Datapath and register file sizes
`define IDX_XLEN        32
`define IDX_REG_AW      5
`define IDX_NUM_REGS    32

// Two multiplier bits retired per cycle
`define IDX_MUL_CYCLES  16

// Major opcodes, instr[6:0]
`define IDX_OPC_OP      7'b0110011
`define IDX_OPC_OP_IMM  7'b0010011
`define IDX_OPC_LUI     7'b0110111
`define IDX_OPC_CUSTOM0 7'b0001011

// Function-7 values, instr[31:25]
`define IDX_F7_BASE     7'b0000000
`define IDX_F7_MULDIV   7'b0000001
`define IDX_F7_SUB      7'b0100000

// Function-3 values, instr[14:12]
`define IDX_F3_ADD      3'b000
`define IDX_F3_XOR      3'b100
`define IDX_F3_OR       3'b110
`define IDX_F3_AND      3'b111

`endif

// ==== design/idx_decoder.sv ====
// Combinational instruction decoder
// Op class and ALU op from opcode and function fields, I/U immediates
`timescale 1ns/1ps
`include "idx_consts.svh"

module idx_decoder (
  input  logic [31:0]        instr_i,
  output idx_pkg::dec_ctrl_t dec_o
);

  import idx_pkg::*;

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`IDX_XLEN-1:0] imm_i_type;
  logic [`IDX_XLEN-1:0] imm_u_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended 12-bit immediate
  assign imm_i_type = {{(`IDX_XLEN - 12){instr_i[31]}}, instr_i[31:20]};
  // Upper immediate, low 12 bits cleared
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    // Register fields sit at fixed positions
    dec_o.rs1      = instr_i[19:15];
    dec_o.rs2      = instr_i[24:20];
    dec_o.rd       = instr_i[11:7];
    dec_o.imm      = imm_i_type;
    dec_o.use_imm  = 1'b0;
    dec_o.alu_op   = ALU_ADD;
    // Anything not matched below stays illegal
    dec_o.op_class = CLS_ILLEGAL;

    unique case (opcode)
      `IDX_OPC_OP: begin
        if (funct7 == `IDX_F7_BASE) begin
          dec_o.op_class = CLS_ALU;
          unique case (funct3)
            `IDX_F3_ADD: dec_o.alu_op = ALU_ADD;
            `IDX_F3_XOR: dec_o.alu_op = ALU_XOR;
            `IDX_F3_OR:  dec_o.alu_op = ALU_OR;
            `IDX_F3_AND: dec_o.alu_op = ALU_AND;
            // SLL, SLT, SLTU, SRL are not kept
            default:     dec_o.op_class = CLS_ILLEGAL;
          endcase
        end else if (funct7 == `IDX_F7_SUB && funct3 == `IDX_F3_ADD) begin
          dec_o.op_class = CLS_ALU;
          dec_o.alu_op   = ALU_SUB;
        end else if (funct7 == `IDX_F7_MULDIV && funct3 == `IDX_F3_ADD) begin
          // Only MUL of the M group, DIV and the high products are illegal
          dec_o.op_class = CLS_MUL;
        end
      end

      `IDX_OPC_OP_IMM: begin
        // ADDI only
        if (funct3 == `IDX_F3_ADD) begin
          dec_o.op_class = CLS_ALU;
          dec_o.use_imm  = 1'b1;
        end
      end

      `IDX_OPC_LUI: begin
        dec_o.op_class = CLS_ALU;
        dec_o.alu_op   = ALU_PASS_B;
        dec_o.imm      = imm_u_type;
        dec_o.use_imm  = 1'b1;
      end

      `IDX_OPC_CUSTOM0: begin
        // MAC is R-type with the MULDIV funct7 and funct3 000
        if (funct7 == `IDX_F7_MULDIV && funct3 == `IDX_F3_ADD) begin
          dec_o.op_class = CLS_MAC;
        end
      end

      default: begin
        dec_o.op_class = CLS_ILLEGAL;
      end
    endcase
  end

endmodule

// ==== design/idx_ex_unit.sv ====
// EX unit with combinational ALU
// Iterative shift-add multiplier, two multiplier bits per cycle
`timescale 1ns/1ps
`include "idx_consts.svh"

module idx_ex_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  idx_pkg::ex_req_t     req_i,
  output logic [`IDX_XLEN-1:0] alu_result_o,
  output logic [`IDX_XLEN-1:0] product_o,
  output logic                 mul_done_o
);

  import idx_pkg::*;

  localparam int CntW = $clog2(`IDX_MUL_CYCLES);

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_i.alu_op)
      ALU_ADD:    alu_result_o = req_i.op_a + req_i.op_b;
      ALU_SUB:    alu_result_o = req_i.op_a - req_i.op_b;
      ALU_AND:    alu_result_o = req_i.op_a & req_i.op_b;
      ALU_OR:     alu_result_o = req_i.op_a | req_i.op_b;
      ALU_XOR:    alu_result_o = req_i.op_a ^ req_i.op_b;
      ALU_PASS_B: alu_result_o = req_i.op_b;
      default:    alu_result_o = req_i.op_a + req_i.op_b;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  logic [`IDX_XLEN-1:0] mul_a_q;
  logic [`IDX_XLEN-1:0] mul_b_q;
  logic [`IDX_XLEN-1:0] acc_q;
  logic [`IDX_XLEN-1:0] src_a;
  logic [`IDX_XLEN-1:0] src_b;
  logic [`IDX_XLEN-1:0] partial;
  logic [CntW-1:0]      cnt_q;
  logic                 mul_busy_q;
  logic                 done_q;

  // Start cycle works on the fresh operands, later cycles on the shifted copies
  assign src_a = req_i.mul_start ? req_i.op_a : mul_a_q;
  assign src_b = req_i.mul_start ? req_i.op_b : mul_b_q;

  // Partial product of A and the two lowest bits of B
  always_comb begin
    partial = '0;
    if (src_b[0]) begin
      partial = partial + src_a;
    end
    if (src_b[1]) begin
      partial = partial + {src_a[`IDX_XLEN-2:0], 1'b0};
    end
  end

  // Operand shifters and accumulator, low word only
  always_ff @(posedge clk_i) begin
    if (req_i.mul_start) begin
      acc_q <= partial;
    end else if (mul_busy_q) begin
      acc_q <= acc_q + partial;
    end
    if (req_i.mul_start || mul_busy_q) begin
      mul_a_q <= src_a << 2;
      mul_b_q <= src_b >> 2;
    end
  end

  // Iteration count, first step taken in the start cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      mul_busy_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (req_i.mul_start) begin
        cnt_q      <= CntW'(`IDX_MUL_CYCLES - 1);
        mul_busy_q <= 1'b1;
      end else if (mul_busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CntW'(1)) begin
          // Last step, product complete next cycle
          mul_busy_q <= 1'b0;
          done_q     <= 1'b1;
        end
      end
    end
  end

  // Product stays in the accumulator until the next start
  assign product_o  = acc_q;
  assign mul_done_o = done_q;

endmodule

// ==== design/idx_id_ctrl.sv ====
// Issue controller with the FIRST_CYCLE/MULTI_CYCLE FSM
// Operand muxes, MUL and MAC sequencing, registered writeback
`timescale 1ns/1ps
`include "idx_consts.svh"

module idx_id_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_valid_i,
  input  idx_pkg::dec_ctrl_t     dec_i,
  output logic [`IDX_REG_AW-1:0] raddr_a_o,
  output logic [`IDX_REG_AW-1:0] raddr_b_o,
  input  logic [`IDX_XLEN-1:0]   rdata_a_i,
  input  logic [`IDX_XLEN-1:0]   rdata_b_i,
  output idx_pkg::ex_req_t       ex_req_o,
  input  logic [`IDX_XLEN-1:0]   alu_result_i,
  input  logic [`IDX_XLEN-1:0]   product_i,
  input  logic                   mul_done_i,
  output logic                   rf_we_o,
  output idx_pkg::wb_t           wb_o,
  output logic                   wb_valid_o,
  output logic                   illegal_o,
  output logic                   busy_o
);

  import idx_pkg::*;

  typedef enum logic { FIRST_CYCLE, MULTI_CYCLE } id_fsm_e;

  id_fsm_e                id_fsm_q;
  id_fsm_e                id_fsm_d;
  logic                   acc_phase_q;
  logic                   acc_phase_d;
  op_class_e              class_q;
  logic [`IDX_REG_AW-1:0] rd_q;
  logic                   busy_q;
  logic                   accept;
  logic                   is_mul_class;
  logic                   wb_valid_d;
  logic                   wb_valid_q;
  logic                   illegal_q;
  wb_t                    wb_d;
  wb_t                    wb_q;

  // Strobes while busy are dropped
  assign accept       = instr_valid_i && (id_fsm_q == FIRST_CYCLE) && !busy_q;
  assign is_mul_class = (dec_i.op_class == CLS_MUL) || (dec_i.op_class == CLS_MAC);

  ////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////

  // Port A re-reads the saved rd in the MAC accumulate step
  assign raddr_a_o = acc_phase_q ? rd_q : dec_i.rs1;
  assign raddr_b_o = dec_i.rs2;

  always_comb begin
    ex_req_o.alu_op    = dec_i.alu_op;
    ex_req_o.op_a      = rdata_a_i;
    ex_req_o.op_b      = dec_i.use_imm ? dec_i.imm : rdata_b_i;
    ex_req_o.mul_start = accept && is_mul_class;
    if (acc_phase_q) begin
      // Old rd plus held product
      ex_req_o.alu_op = ALU_ADD;
      ex_req_o.op_b   = product_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    id_fsm_d    = id_fsm_q;
    acc_phase_d = acc_phase_q;
    unique case (id_fsm_q)
      FIRST_CYCLE: begin
        if (accept && is_mul_class) begin
          id_fsm_d = MULTI_CYCLE;
        end
      end
      MULTI_CYCLE: begin
        if (acc_phase_q) begin
          // Sum registered this cycle
          id_fsm_d    = FIRST_CYCLE;
          acc_phase_d = 1'b0;
        end else if (mul_done_i) begin
          if (class_q == CLS_MAC) begin
            acc_phase_d = 1'b1;
          end else begin
            id_fsm_d = FIRST_CYCLE;
          end
        end
      end
      default: id_fsm_d = FIRST_CYCLE;
    endcase
  end

  // Writeback source and strobe
  always_comb begin
    wb_valid_d = 1'b0;
    wb_d.rd    = rd_q;
    wb_d.data  = alu_result_i;
    if (accept) begin
      wb_d.rd    = dec_i.rd;
      wb_valid_d = (dec_i.op_class == CLS_ALU);
    end else if (id_fsm_q == MULTI_CYCLE) begin
      if (acc_phase_q) begin
        wb_valid_d = 1'b1;
      end else if (mul_done_i && class_q == CLS_MUL) begin
        wb_valid_d = 1'b1;
        wb_d.data  = product_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q    <= FIRST_CYCLE;
      acc_phase_q <= 1'b0;
      class_q     <= CLS_ALU;
      busy_q      <= 1'b0;
      wb_valid_q  <= 1'b0;
      illegal_q   <= 1'b0;
    end else begin
      id_fsm_q    <= id_fsm_d;
      acc_phase_q <= acc_phase_d;
      wb_valid_q  <= wb_valid_d;
      // Illegal encodings only flag, no write
      illegal_q   <= accept && (dec_i.op_class == CLS_ILLEGAL);
      if (accept) begin
        class_q <= dec_i.op_class;
      end
      // Busy holds through the writeback cycle of MUL and MAC
      if (accept && is_mul_class) begin
        busy_q <= 1'b1;
      end else if (wb_valid_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  // rd kept for MAC re-read and late writeback
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_q <= dec_i.rd;
    end
    if (wb_valid_d) begin
      wb_q <= wb_d;
    end
  end

  assign rf_we_o    = wb_valid_q;
  assign wb_o       = wb_q;
  assign wb_valid_o = wb_valid_q;
  assign illegal_o  = illegal_q;
  assign busy_o     = busy_q;

endmodule

// ==== design/idx_pkg.sv ====
// Shared enums and packed structs of the decode-execute slice
// Decoder output, EX request and writeback record
`include "idx_consts.svh"

package idx_pkg;

  // Instruction class, picks the controller sequence
  typedef enum logic [1:0] {
    CLS_ALU     = 2'd0,
    CLS_MUL     = 2'd1,
    CLS_MAC     = 2'd2,
    CLS_ILLEGAL = 2'd3
  } op_class_e;

  // ALU operation, PASS_B forwards operand B for LUI
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
  } alu_op_e;

  // Decoded instruction fields
  typedef struct packed {
    op_class_e                op_class;
    alu_op_e                  alu_op;
    logic [`IDX_REG_AW-1:0]   rs1;
    logic [`IDX_REG_AW-1:0]   rs2;
    logic [`IDX_REG_AW-1:0]   rd;
    logic [`IDX_XLEN-1:0]     imm;
    logic                     use_imm;
  } dec_ctrl_t;

  // Request from the controller to the EX unit
  typedef struct packed {
    alu_op_e                  alu_op;
    logic [`IDX_XLEN-1:0]     op_a;
    logic [`IDX_XLEN-1:0]     op_b;
    logic                     mul_start;
  } ex_req_t;

  // Writeback record
  typedef struct packed {
    logic [`IDX_REG_AW-1:0]   rd;
    logic [`IDX_XLEN-1:0]     data;
  } wb_t;

endpackage

// ==== design/idx_regfile.sv ====
// Register file, 32 entries, two async read ports, one write port
// x0 reads as zero, writes to it are dropped
`timescale 1ns/1ps
`include "idx_consts.svh"

module idx_regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`IDX_REG_AW-1:0] raddr_a_i,
  input  logic [`IDX_REG_AW-1:0] raddr_b_i,
  output logic [`IDX_XLEN-1:0]   rdata_a_o,
  output logic [`IDX_XLEN-1:0]   rdata_b_o,
  input  logic                   we_i,
  input  idx_pkg::wb_t           wb_i
);

  logic [`IDX_XLEN-1:0] regs_q [`IDX_NUM_REGS];
  logic                 wr_en;

  // x0 never written, so it keeps its reset value of zero
  assign wr_en = we_i && (wb_i.rd != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `IDX_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wb_i.rd] <= wb_i.data;
    end
  end

  // Write-through, the value being written is visible in its writeback cycle
  assign rdata_a_o = (wr_en && raddr_a_i == wb_i.rd) ? wb_i.data : regs_q[raddr_a_i];
  assign rdata_b_o = (wr_en && raddr_b_i == wb_i.rd) ? wb_i.data : regs_q[raddr_b_i];

endmodule

// ==== design/idx_top.sv ====
// Top level of the decode-execute slice
// Decoder, register file, EX unit and issue controller
`timescale 1ns/1ps
`include "idx_consts.svh"

module idx_top (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         instr_valid_i,
  input  logic [31:0]  instr_i,
  output logic         wb_valid_o,
  output idx_pkg::wb_t wb_o,
  output logic         illegal_o,
  output logic         busy_o
);

  import idx_pkg::*;

  dec_ctrl_t              dec;
  ex_req_t                ex_req;
  logic [`IDX_REG_AW-1:0] raddr_a;
  logic [`IDX_REG_AW-1:0] raddr_b;
  logic [`IDX_XLEN-1:0]   rdata_a;
  logic [`IDX_XLEN-1:0]   rdata_b;
  logic [`IDX_XLEN-1:0]   alu_result;
  logic [`IDX_XLEN-1:0]   product;
  logic                   mul_done;
  logic                   rf_we;

  idx_decoder u_decoder (
    .instr_i (instr_i),
    .dec_o   (dec)
  );

  // Write port fed by the controller's writeback record
  idx_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .wb_i      (wb_o)
  );

  idx_ex_unit u_ex_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (ex_req),
    .alu_result_o (alu_result),
    .product_o    (product),
    .mul_done_o   (mul_done)
  );

  idx_id_ctrl u_id_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .dec_i         (dec),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .ex_req_o      (ex_req),
    .alu_result_i  (alu_result),
    .product_i     (product),
    .mul_done_i    (mul_done),
    .rf_we_o       (rf_we),
    .wb_o          (wb_o),
    .wb_valid_o    (wb_valid_o),
    .illegal_o     (illegal_o),
    .busy_o        (busy_o)
  );

endmodule

// ==== files.f ====
+incdir+design
+incdir+verification
design/idx_pkg.sv
design/idx_decoder.sv
design/idx_regfile.sv
design/idx_ex_unit.sv
design/idx_id_ctrl.sv
design/idx_top.sv
verification/idx_props.sv
verification/idx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module idx_tb -o idx_sim \
  && ./obj_dir/idx_sim | tee /dev/stderr | grep -qx "TB PASSED" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== verification/idx_props.sv ====
// Concurrent handshake assertions bound to the top level
`timescale 1ns/1ps

module idx_props (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_valid_i,
  input logic wb_valid_i,
  input logic illegal_i,
  input logic busy_i
);

  int assert_fail_cnt;

  initial assert_fail_cnt = 0;

  // Environment sends only while the core is idle
  strobe_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> !busy_i)
    else begin
      assert_fail_cnt++;
      $error("instruction strobe while busy_o is high");
    end

  // One kind of result per cycle
  wb_or_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_valid_i && illegal_i))
    else begin
      assert_fail_cnt++;
      $error("wb_valid_o and illegal_o high together");
    end

  // busy_o releases right after the writeback
  busy_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_i) |-> $past(wb_valid_i))
    else begin
      assert_fail_cnt++;
      $error("busy_o fell without a writeback before");
    end

endmodule

bind idx_top idx_props u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .instr_valid_i (instr_valid_i),
  .wb_valid_i    (wb_valid_o),
  .illegal_i     (illegal_o),
  .busy_i        (busy_o)
);

// ==== verification/idx_tb_checks.svh ====
// Typed compare tasks for writeback records, flags and cycle counts
// LCG random-number generator for the MUL and MAC rounds
`ifndef IDX_TB_CHECKS_SVH
`define IDX_TB_CHECKS_SVH

// Writeback record, rd and data together
task automatic check_wb(input wb_t got, input wb_t exp, input string name);
  if (got !== exp) begin
    err_cnt++;
    $display("error at %0t ns: %s got rd=%0d data=%08h, expected rd=%0d data=%08h",
             $time, name, got.rd, got.data, exp.rd, exp.data);
  end
endtask

// Single-bit status outputs
task automatic check_flag(input logic got, input logic exp, input string name);
  if (got !== exp) begin
    err_cnt++;
    $display("error at %0t ns: %s got %0b, expected %0b", $time, name, got, exp);
  end
endtask

// Cycles from the accepting edge to the result
task automatic check_count(input int got, input int exp, input string name);
  if (got != exp) begin
    err_cnt++;
    $display("error at %0t ns: %s got %0d cycles, expected %0d", $time, name, got, exp);
  end
endtask

// Full-period 32-bit LCG
function automatic logic [31:0] lcg_next();
  rng_state = rng_state * 32'd1664525 + 32'd1013904223;
  return rng_state;
endfunction

`endif

// ==== verification/idx_tb.sv ====
// Testbench for the decode-execute slice
// Clock, reset, file-driven tests, random MUL and MAC rounds, summary
`timescale 1ns/1ps
`include "idx_consts.svh"

module idx_tb;

  import idx_pkg::*;

  localparam int wait_limit = 100;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        wb_valid;
  wb_t         wb;
  logic        illegal;
  logic        busy;

  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  bit          aborted;
  logic [31:0] rng_state;
  // Mirror of the architectural registers
  logic [31:0] model_regs [`IDX_NUM_REGS];
  // Tests read from the data file
  logic [31:0] file_word [$];
  bit          file_ill [$];
  wb_t         file_wb [$];

  `include "idx_tb_checks.svh"

  idx_top uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .wb_valid_o    (wb_valid),
    .wb_o          (wb),
    .illegal_o     (illegal),
    .busy_o        (busy)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Encoders and expected values
  ////////////////////////////////////////////////////////////

  // R-type word with funct3 000
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input int rd, input logic [6:0] opc);
    return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [11:0] imm, input int rs1, input int rd);
    return {imm, 5'(rs1), 3'b000, 5'(rd), `IDX_OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [19:0] imm, input int rd);
    return {imm, 5'(rd), `IDX_OPC_LUI};
  endfunction

  function automatic wb_t make_wb(input int rd, input logic [31:0] data);
    wb_t w;
    w.rd   = 5'(rd);
    w.data = data;
    return w;
  endfunction

  // Cycles from the accepting edge to the result strobe
  function automatic int expected_latency(input logic [31:0] word, input bit is_ill);
    if (is_ill) return 1;
    if (word[6:0] == `IDX_OPC_CUSTOM0) return `IDX_MUL_CYCLES + 2;
    if (word[6:0] == `IDX_OPC_OP && word[31:25] == `IDX_F7_MULDIV) return `IDX_MUL_CYCLES + 1;
    return 1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Test sequencing
  ////////////////////////////////////////////////////////////

  // Test file columns are instruction, kind, rd and data
  task automatic read_tests();
    int          fd;
    string       line;
    logic [31:0] word;
    byte         kind;
    int          rd;
    logic [31:0] data;
    fd = $fopen("verification/idx_tests.txt", "r");
    if (fd == 0) begin
      aborted = 1'b1;
      $display("could not open the test file verification/idx_tests.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        // Header and blank lines do not scan to four fields
        if ($sscanf(line, "%h %c %d %h", word, kind, rd, data) == 4) begin
          file_word.push_back(word);
          file_ill.push_back(kind == "I");
          file_wb.push_back(make_wb(rd, data));
        end
      end
      $fclose(fd);
    end
  endtask

  // One strobe, then wait for the result and the release of busy_o
  task automatic run_test(input string name, input logic [31:0] word, input bit exp_ill,
                          input wb_t exp_wb);
    int cycles;
    int errs_before;
    int lat;
    bit seen;
    if (!aborted) begin
      errs_before = err_cnt;
      lat         = expected_latency(word, exp_ill);
      seen        = 1'b0;
      cycles      = 0;
      test_cnt++;
      instr_valid = 1'b1;
      instr       = word;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
      // busy_o must stay high while a MUL or MAC is running
      while (!seen && cycles < wait_limit) begin
        cycles++;
        if (wb_valid || illegal) begin
          seen = 1'b1;
        end else begin
          if (lat > 1) check_flag(busy, 1'b1, "busy_o");
          @(posedge clk);
          #1;
        end
      end
      if (!seen) begin
        aborted = 1'b1;
        $display("timeout: %s gave no writeback and no illegal flag in %0d cycles",
                 name, wait_limit);
      end else begin
        check_flag(illegal, exp_ill, "illegal_o");
        check_flag(wb_valid, !exp_ill, "wb_valid_o");
        check_flag(busy, lat > 1, "busy_o");
        check_count(cycles, lat, "latency");
        if (!exp_ill) begin
          check_wb(wb, exp_wb, "wb_o");
          if (exp_wb.rd != '0) model_regs[exp_wb.rd] = exp_wb.data;
        end
        cycles = 0;
        while (busy && cycles < wait_limit) begin
          @(posedge clk);
          #1;
          cycles++;
        end
        // busy_o drops one cycle after a MUL or MAC writeback
        if (busy) begin
          aborted = 1'b1;
          $display("timeout: busy_o stayed high after %s", name);
        end else if (lat > 1) begin
          check_count(cycles, 1, "busy_o fall");
        end
      end
      if (aborted || err_cnt != errs_before) fail_cnt++;
      $display("test %0d %s: %s", test_cnt, name,
               (!aborted && err_cnt == errs_before) ? "ok" : "mismatch");
    end
  endtask

  // LUI then ADDI with the upper part rounded for the signed low immediate
  task automatic load_const(input int rd, input logic [31:0] val);
    logic [31:0] upper;
    logic [31:0] hi_val;
    upper  = (val + 32'h800) >> 12;
    hi_val = {upper[19:0], 12'b0};
    run_test($sformatf("lui x%0d", rd), enc_lui(upper[19:0], rd), 1'b0, make_wb(rd, hi_val));
    run_test($sformatf("addi x%0d", rd), enc_addi(val[11:0], rd, rd), 1'b0,
             make_wb(rd, hi_val + {{20{val[11]}}, val[11:0]}));
  endtask

  initial begin
    logic [31:0] prod;
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    err_cnt     = 0;
    test_cnt    = 0;
    fail_cnt    = 0;
    aborted     = 1'b0;
    rng_state   = 32'd81468;
    for (int i = 0; i < `IDX_NUM_REGS; i++) model_regs[i] = '0;
    read_tests();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < file_word.size(); i++) begin
      run_test($sformatf("file test %0d", i + 1), file_word[i], file_ill[i], file_wb[i]);
    end
    // Random MUL and accumulating MAC rounds on x16..x19
    for (int r = 0; r < 3; r++) begin
      load_const(16, lcg_next());
      load_const(17, lcg_next());
      prod = model_regs[16] * model_regs[17];
      run_test("mul x18", enc_r(`IDX_F7_MULDIV, 17, 16, 18, `IDX_OPC_OP), 1'b0,
               make_wb(18, prod));
      run_test("mac x19", enc_r(`IDX_F7_MULDIV, 17, 16, 19, `IDX_OPC_CUSTOM0), 1'b0,
               make_wb(19, model_regs[19] + prod));
      // Second MAC adds on top of the first sum
      prod = model_regs[18] * model_regs[16];
      run_test("mac x19 again", enc_r(`IDX_F7_MULDIV, 16, 18, 19, `IDX_OPC_CUSTOM0), 1'b0,
               make_wb(19, model_regs[19] + prod));
    end
    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             test_cnt, fail_cnt, err_cnt, uut.u_props.assert_fail_cnt);
    if (!aborted && fail_cnt == 0 && err_cnt == 0 && uut.u_props.assert_fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/idx_tests.txt ====
# instr kind rd data, instr and data in hex, rd in decimal
# kind W expects a writeback of data to rd, kind I an illegal flag (rd and data unused)
06400093 W 1  00000064
FF900113 W 2  FFFFFFF9
123451B7 W 3  12345000
67818193 W 3  12345678
F0F0F237 W 4  F0F0F000
7FF00293 W 5  000007FF
00208333 W 6  0000005D
402083B3 W 7  0000006B
0041F433 W 8  10305000
0041E4B3 W 9  F2F4F678
0041C533 W 10 E2C4A678
00508033 W 0  00000863
001005B3 W 11 00000064
02510633 W 12 FFFFC807
021186B3 W 13 1C71C6E0
0250868B W 13 1C74E67C
0221068B W 13 1C74E6AD
00208463 I 0  00000000
00012083 I 0  00000000
0220C1B3 I 0  00000000
00008733 W 14 00000064
000187B3 W 15 12345678
